//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := axi_mem_slave_tb
FILELIST := list.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- hw/axi_mem_array.sv
`timescale 1ns/1ps

module axi_mem_array #(
  parameter int data_w    = 32,
  parameter int mem_words = 256
) (
  input  logic                         aclk,
  input  logic                         we,
  input  logic [$clog2(mem_words)-1:0] waddr,
  input  logic [data_w-1:0]            wdata,
  input  logic [data_w/8-1:0]          wstrb,
  input  logic [$clog2(mem_words)-1:0] raddr,
  output logic [data_w-1:0]            rdata
);

  logic [data_w-1:0] mem [mem_words];  // Flop array at simulation scale

  // Byte lanes without a strobe keep their old value
  always_ff @(posedge aclk) begin
    if (we) begin
      for (int i = 0; i < data_w / 8; i++) begin
        if (wstrb[i]) begin
          mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  assign rdata = mem[raddr];  // Combinational read

endmodule

//--- hw/axi_mem_pkg.sv
package axi_mem_pkg;

  // Response codes on B and R
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;  // Unsupported burst or size
  localparam logic [1:0] resp_decerr = 2'b11;  // Beat beyond the memory

  // Burst codes on awburst and arburst; 2'b11 is reserved
  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;
  localparam logic [1:0] burst_wrap  = 2'b10;  // Answered with SLVERR

  // awlen and arlen width, 1 to 16 beats
  localparam int len_w = 4;

endpackage

//--- hw/axi_mem_slave.sv
`timescale 1ns/1ps

module axi_mem_slave #(
  parameter int data_w    = 32,
  parameter int addr_w    = 32,
  parameter int id_w      = 4,
  parameter int mem_words = 256
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic [id_w-1:0]               awid,
  input  logic [addr_w-1:0]             awaddr,
  input  logic [axi_mem_pkg::len_w-1:0] awlen,
  input  logic [2:0]                    awsize,
  input  logic [1:0]                    awburst,
  input  logic [1:0]                    awlock,   // Ignored
  input  logic [3:0]                    awcache,  // Ignored
  input  logic [2:0]                    awprot,   // Ignored
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [data_w-1:0]             wdata,
  input  logic [data_w/8-1:0]           wstrb,
  input  logic                          wlast,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [id_w-1:0]               bid,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [id_w-1:0]               arid,
  input  logic [addr_w-1:0]             araddr,
  input  logic [axi_mem_pkg::len_w-1:0] arlen,
  input  logic [2:0]                    arsize,
  input  logic [1:0]                    arburst,
  input  logic [1:0]                    arlock,   // Ignored
  input  logic [3:0]                    arcache,  // Ignored
  input  logic [2:0]                    arprot,   // Ignored
  input  logic                          arvalid,
  output logic                          arready,
  output logic [id_w-1:0]               rid,
  output logic [data_w-1:0]             rdata,
  output logic [1:0]                    rresp,
  output logic                          rlast,
  output logic                          rvalid,
  input  logic                          rready
);

  logic                         mem_we;
  logic [$clog2(mem_words)-1:0] mem_waddr;
  logic [data_w-1:0]            mem_wdata;
  logic [data_w/8-1:0]          mem_wstrb;
  logic [$clog2(mem_words)-1:0] mem_raddr;
  logic [data_w-1:0]            mem_rdata;

  // AW, W and B channels
  axi_write_ctrl #(
    .data_w    (data_w),
    .addr_w    (addr_w),
    .id_w      (id_w),
    .mem_words (mem_words)
  ) write_ctrl_inst (.*);

  // AR and R channels
  axi_read_ctrl #(
    .data_w    (data_w),
    .addr_w    (addr_w),
    .id_w      (id_w),
    .mem_words (mem_words)
  ) read_ctrl_inst (.*);

  axi_mem_array #(
    .data_w    (data_w),
    .mem_words (mem_words)
  ) mem_array_inst (
    .aclk  (aclk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .wstrb (mem_wstrb),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

endmodule

//--- hw/axi_read_ctrl.sv
`timescale 1ns/1ps

module axi_read_ctrl #(
  parameter int data_w    = 32,
  parameter int addr_w    = 32,
  parameter int id_w      = 4,
  parameter int mem_words = 256
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic [id_w-1:0]               arid,
  input  logic [addr_w-1:0]             araddr,
  input  logic [axi_mem_pkg::len_w-1:0] arlen,
  input  logic [2:0]                    arsize,
  input  logic [1:0]                    arburst,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [id_w-1:0]               rid,
  output logic [data_w-1:0]             rdata,
  output logic [1:0]                    rresp,
  output logic                          rlast,
  output logic                          rvalid,
  input  logic                          rready,
  output logic [$clog2(mem_words)-1:0]  mem_raddr,
  input  logic [data_w-1:0]             mem_rdata
);

  localparam int lsb    = $clog2(data_w / 8);
  localparam int word_w = addr_w - lsb;

  logic                          busy;
  logic [word_w-1:0]             word_q;   // Word index of the next beat to load
  logic                          incr_q;
  logic                          unsup_q;
  logic [axi_mem_pkg::len_w-1:0] len_q;
  logic [axi_mem_pkg::len_w-1:0] cnt_q;
  logic [1:0]                    beat_resp;
  logic                          ar_fire;
  logic                          load;

  assign ar_fire = arvalid && arready;
  // First beat, or next beat once the current one is taken
  assign load    = busy && (!rvalid || (rready && !rlast));

  always_comb begin
    if (unsup_q) begin
      beat_resp = axi_mem_pkg::resp_slverr;
    end else if (word_q >= word_w'(mem_words)) begin
      beat_resp = axi_mem_pkg::resp_decerr;
    end else begin
      beat_resp = axi_mem_pkg::resp_okay;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      busy    <= 1'b0;
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end else if (ar_fire) begin
      arready <= 1'b0;
      busy    <= 1'b1;
    end else if (rvalid && rready && rlast) begin
      rvalid  <= 1'b0;
      arready <= 1'b1;
      busy    <= 1'b0;
    end else if (load) begin
      rvalid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_fire) begin
      rid     <= arid;
      word_q  <= araddr[addr_w-1:lsb];
      incr_q  <= (arburst == axi_mem_pkg::burst_incr);
      unsup_q <= !(arburst inside {axi_mem_pkg::burst_incr, axi_mem_pkg::burst_fixed}) ||
                 (arsize != 3'(lsb));
      len_q   <= arlen;
      cnt_q   <= '0;
    end else if (load) begin
      rdata <= (beat_resp == axi_mem_pkg::resp_okay) ? mem_rdata : '0;  // Zero on error
      rresp <= beat_resp;
      rlast <= (cnt_q == len_q);
      cnt_q <= cnt_q + 1'b1;
      if (incr_q) begin
        word_q <= word_q + 1'b1;
      end
    end
  end

  assign mem_raddr = word_q[$clog2(mem_words)-1:0];

endmodule

//--- hw/axi_write_ctrl.sv
`timescale 1ns/1ps

module axi_write_ctrl #(
  parameter int data_w    = 32,
  parameter int addr_w    = 32,
  parameter int id_w      = 4,
  parameter int mem_words = 256
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic [id_w-1:0]               awid,
  input  logic [addr_w-1:0]             awaddr,
  input  logic [axi_mem_pkg::len_w-1:0] awlen,
  input  logic [2:0]                    awsize,
  input  logic [1:0]                    awburst,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [data_w-1:0]             wdata,
  input  logic [data_w/8-1:0]           wstrb,
  input  logic                          wlast,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [id_w-1:0]               bid,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  output logic                          mem_we,
  output logic [$clog2(mem_words)-1:0]  mem_waddr,
  output logic [data_w-1:0]             mem_wdata,
  output logic [data_w/8-1:0]           mem_wstrb
);

  localparam int lsb    = $clog2(data_w / 8);
  localparam int word_w = addr_w - lsb;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_data = 2'd1;
  localparam logic [1:0] st_resp = 2'd2;

  logic [1:0]                    state;
  logic [word_w-1:0]             word_q;     // Word index of the current beat
  logic                          incr_q;
  logic                          unsup_q;    // Bad burst type or narrow size
  logic [axi_mem_pkg::len_w-1:0] len_q;
  logic [axi_mem_pkg::len_w:0]   cnt_q;      // One extra bit to see overrun
  logic [1:0]                    acc_q;      // Worst response so far
  logic [1:0]                    beat_resp;
  logic                          aw_fire;
  logic                          w_fire;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  always_comb begin
    if (unsup_q || cnt_q > {1'b0, len_q}) begin
      beat_resp = axi_mem_pkg::resp_slverr;
    end else if (word_q >= word_w'(mem_words)) begin
      beat_resp = axi_mem_pkg::resp_decerr;
    end else begin
      beat_resp = axi_mem_pkg::resp_okay;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= st_idle;
      awready <= 1'b1;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      case (state)
        st_idle: if (aw_fire) begin
          awready <= 1'b0;
          state   <= st_data;
        end
        st_data: if (w_fire && wlast) begin  // wlast closes the burst
          wready <= 1'b0;
          bvalid <= 1'b1;
          state  <= st_resp;
        end else begin
          wready <= 1'b1;  // One idle cycle after AW
        end
        default: if (bvalid && bready) begin
          bvalid  <= 1'b0;
          awready <= 1'b1;
          state   <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (aw_fire) begin
      bid     <= awid;
      word_q  <= awaddr[addr_w-1:lsb];
      incr_q  <= (awburst == axi_mem_pkg::burst_incr);
      unsup_q <= !(awburst inside {axi_mem_pkg::burst_incr, axi_mem_pkg::burst_fixed}) ||
                 (awsize != 3'(lsb));
      len_q   <= awlen;
      cnt_q   <= '0;
      acc_q   <= axi_mem_pkg::resp_okay;
    end else if (w_fire) begin
      cnt_q <= cnt_q + 1'b1;
      if (incr_q) begin
        word_q <= word_q + 1'b1;  // FIXED stays put
      end
      if (beat_resp != axi_mem_pkg::resp_okay) begin
        acc_q <= beat_resp;
      end
      if (wlast) begin
        bresp <= (beat_resp != axi_mem_pkg::resp_okay) ? beat_resp : acc_q;
      end
    end
  end

  assign mem_we    = w_fire && (beat_resp == axi_mem_pkg::resp_okay);
  assign mem_waddr = word_q[$clog2(mem_words)-1:0];
  assign mem_wdata = wdata;
  assign mem_wstrb = wstrb;

endmodule

//--- list.f
hw/axi_mem_pkg.sv
hw/axi_mem_array.sv
hw/axi_write_ctrl.sv
hw/axi_read_ctrl.sv
hw/axi_mem_slave.sv
verif/axi_mem_slave_chk.sv
verif/axi_mem_slave_tb.sv

//--- verif/axi_mem_slave_chk.sv
`timescale 1ns/1ps

module axi_mem_slave_chk #(
  parameter int data_w = 32,
  parameter int id_w   = 4
) (
  input logic              aclk,
  input logic              aresetn,
  input logic              wready,
  input logic              bvalid,
  input logic              bready,
  input logic [id_w-1:0]   bid,
  input logic [1:0]        bresp,
  input logic              rvalid,
  input logic              rready,
  input logic [id_w-1:0]   rid,
  input logic [data_w-1:0] rdata,
  input logic [1:0]        rresp,
  input logic              rlast
);

  assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid && $stable({bid, bresp}))
    else $error("bvalid or its payload changed before bready");

  assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable({rid, rdata, rresp, rlast}))
    else $error("rvalid or its payload changed before rready");

  // Data and response channels idle right after reset
  assert property (@(posedge aclk) !aresetn |=> !wready && !bvalid && !rvalid)
    else $error("wready, bvalid or rvalid high in the cycle after reset");

endmodule

bind axi_mem_slave axi_mem_slave_chk #(
  .data_w (data_w),
  .id_w   (id_w)
) chk_inst (.*);

//--- verif/axi_mem_slave_tb.sv
`timescale 1ns/1ps

module axi_mem_slave_tb;

  localparam int data_w      = 32;
  localparam int addr_w      = 32;
  localparam int id_w        = 4;
  localparam int mem_words   = 256;
  localparam int total_beats = 360;  // Beats issued over all tests

  logic                          aclk, aresetn;
  logic [id_w-1:0]               awid, arid, bid, rid;
  logic [addr_w-1:0]             awaddr, araddr;
  logic [axi_mem_pkg::len_w-1:0] awlen, arlen;
  logic [2:0]                    awsize, arsize, awprot, arprot;
  logic [1:0]                    awburst, arburst, awlock, arlock, bresp, rresp;
  logic [3:0]                    awcache, arcache;
  logic [data_w-1:0]             wdata, rdata;
  logic [data_w/8-1:0]           wstrb;
  logic                          awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic                          arvalid, arready, rlast, rvalid, rready;

  logic [data_w-1:0]      shadow [mem_words];  // Expected memory contents
  logic [data_w-1:0]      wbuf [16];           // Beats of the next write burst
  logic [data_w/8-1:0]    sbuf [16];
  logic [id_w+data_w+2:0] exp_r [$];           // {rid, rlast, rresp, rdata}
  logic [id_w+1:0]        exp_b [$];           // {bid, bresp}
  logic [id_w+data_w+2:0] r_e;
  logic [id_w+1:0]        b_e;
  logic [31:0]            addr;
  logic [31:0]            seed;
  int                     errs, mark, pass_cnt, fail_cnt;

  axi_mem_slave #(
    .data_w    (data_w),
    .addr_w    (addr_w),
    .id_w      (id_w),
    .mem_words (mem_words)
  ) axi_mem_slave_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic int beat_word(input logic [31:0] start, input logic [1:0] burst,
                                   input int beat);
    return int'(start) / (data_w / 8) + ((burst == axi_mem_pkg::burst_incr) ? beat : 0);
  endfunction

  // {resp, data} that one beat should carry
  function automatic logic [data_w+1:0] expect_beat(input logic [31:0] start,
                                                    input logic [1:0] burst, input int beat);
    int word;
    word = beat_word(start, burst, beat);
    if (!(burst inside {axi_mem_pkg::burst_fixed, axi_mem_pkg::burst_incr})) begin
      return {axi_mem_pkg::resp_slverr, {data_w{1'b0}}};
    end else if (word >= mem_words) begin
      return {axi_mem_pkg::resp_decerr, {data_w{1'b0}}};
    end
    return {axi_mem_pkg::resp_okay, shadow[word]};
  endfunction

  task automatic write_burst(input logic [id_w-1:0] id, input logic [31:0] start,
                             input int len, input logic [1:0] burst);
    logic [data_w+1:0] e;
    logic [1:0]        resp;
    int                word;
    resp = axi_mem_pkg::resp_okay;
    for (int i = 0; i <= len; i++) begin
      e    = expect_beat(start, burst, i);
      word = beat_word(start, burst, i);
      if (e[data_w+1:data_w] != axi_mem_pkg::resp_okay) begin
        if (resp != axi_mem_pkg::resp_slverr) begin
          resp = e[data_w+1:data_w];  // SLVERR outranks DECERR
        end
      end else begin
        for (int b = 0; b < data_w / 8; b++) begin
          if (sbuf[i][b]) begin
            shadow[word][b*8 +: 8] = wbuf[i][b*8 +: 8];  // Beats merge in order
          end
        end
      end
    end
    exp_b.push_back({id, resp});
    @(posedge aclk);
    awid    <= id;
    awaddr  <= start;
    awlen   <= 4'(len);
    awburst <= burst;
    awvalid <= 1'b1;
    @(posedge aclk);
    while (!awready) @(posedge aclk);
    awvalid <= 1'b0;
    for (int i = 0; i <= len; i++) begin
      wdata  <= wbuf[i];
      wstrb  <= sbuf[i];
      wlast  <= (i == len);
      wvalid <= 1'b1;
      @(posedge aclk);
      while (!wready) @(posedge aclk);
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    do begin
      bready <= ($urandom % 4) != 0;  // Back-pressure on B now and then
      @(posedge aclk);
    end while (!(bvalid && bready));
    bready <= 1'b0;
  endtask

  task automatic read_burst(input logic [id_w-1:0] id, input logic [31:0] start,
                            input int len, input logic [1:0] burst);
    for (int i = 0; i <= len; i++) begin
      exp_r.push_back({id, (i == len), expect_beat(start, burst, i)});
    end
    @(posedge aclk);
    arid    <= id;
    araddr  <= start;
    arlen   <= 4'(len);
    arburst <= burst;
    arvalid <= 1'b1;
    @(posedge aclk);
    while (!arready) @(posedge aclk);
    arvalid <= 1'b0;
    do begin
      rready <= ($urandom % 4) != 0;  // Stall about one cycle in four
      @(posedge aclk);
    end while (!(rvalid && rready && rlast));
    rready <= 1'b0;
  endtask

  task automatic end_test(input string name, input int first_err);
    @(posedge aclk);  // Let the last transfer be compared
    if (errs == first_err) begin
      pass_cnt++;
      $display("test %-28s ok", name);
    end else begin
      fail_cnt++;
      $display("test %-28s %0d errors", name, errs - first_err);
    end
  endtask

  // Compare every R and B transfer against the queued expectations
  always @(posedge aclk) begin
    if (rvalid && rready) begin
      if (exp_r.size() == 0) begin
        $display("An R beat arrived while no read burst was outstanding");
        errs++;
      end else begin
        r_e = exp_r.pop_front();
        if (rdata !== r_e[data_w-1:0]) begin
          $display("[FAIL] rdata expected %h got %h", r_e[data_w-1:0], rdata);
          errs++;
        end
        if (rresp !== r_e[data_w+1:data_w]) begin
          $display("[FAIL] rresp expected %h got %h", r_e[data_w+1:data_w], rresp);
          errs++;
        end
        if (rlast !== r_e[data_w+2]) begin
          $display("[FAIL] rlast expected %h got %h", r_e[data_w+2], rlast);
          errs++;
        end
        if (rid !== r_e[id_w+data_w+2:data_w+3]) begin
          $display("[FAIL] rid expected %h got %h", r_e[id_w+data_w+2:data_w+3], rid);
          errs++;
        end
      end
    end
    if (bvalid && bready) begin
      if (exp_b.size() == 0) begin
        $display("A B response arrived while no write burst was outstanding");
        errs++;
      end else begin
        b_e = exp_b.pop_front();
        if (bresp !== b_e[1:0]) begin
          $display("[FAIL] bresp expected %h got %h", b_e[1:0], bresp);
          errs++;
        end
        if (bid !== b_e[id_w+1:2]) begin
          $display("[FAIL] bid expected %h got %h", b_e[id_w+1:2], bid);
          errs++;
        end
      end
    end
  end

  initial begin
    repeat (total_beats * 20 + 200) @(posedge aclk);
    $display("Timeout: the tests did not finish within their cycle budget");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    seed = 32'h4770;
    void'($urandom(seed));
    errs     = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    aresetn  = 1'b0;
    {awid, awaddr, awlen, awburst, awlock, awcache, awprot, awvalid} = '0;
    {wdata, wstrb, wlast, wvalid, bready} = '0;
    {arid, araddr, arlen, arburst, arlock, arcache, arprot, arvalid, rready} = '0;
    awsize = 3'd2;  // Full 32-bit beats
    arsize = 3'd2;
    repeat (3) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);

    mark = errs;
    if ({awready, arready, wready, bvalid, rvalid} !== 5'b11000) begin
      $display("[FAIL] awready,arready,wready,bvalid,rvalid expected %h got %h", 5'b11000,
               {awready, arready, wready, bvalid, rvalid});
      errs++;
    end
    end_test("reset values", mark);

    mark = errs;
    for (int blk = 0; blk < mem_words / 16; blk++) begin
      for (int i = 0; i < 16; i++) begin
        wbuf[i] = 32'h9e37_79b9 * (blk * 16 + i + 1);  // Varies with every address bit
        sbuf[i] = 4'hf;
      end
      write_burst(4'(blk), 32'(blk * 64), 15, axi_mem_pkg::burst_incr);
    end
    end_test("memory fill", mark);

    for (int pass = 0; pass < 2; pass++) begin
      mark = errs;
      repeat (8) begin
        addr    = ($urandom % mem_words) * 4;
        wbuf[0] = $urandom;
        sbuf[0] = (pass == 0) ? 4'hf : 4'($urandom);
        write_burst(4'($urandom), addr, 0, axi_mem_pkg::burst_incr);
        read_burst(4'($urandom), addr, 0, axi_mem_pkg::burst_incr);
      end
      end_test((pass == 0) ? "single beat full strobe" : "single beat partial strobe", mark);
    end

    mark = errs;
    for (int i = 0; i < 16; i++) begin
      wbuf[i] = $urandom;
      sbuf[i] = (i < 8) ? 4'hf : 4'($urandom);  // Later beats also feed the FIXED test
    end
    write_burst(4'h3, 32'h100, 15, axi_mem_pkg::burst_incr);
    read_burst(4'h5, 32'h100, 15, axi_mem_pkg::burst_incr);
    end_test("16-beat incr burst", mark);

    mark = errs;
    for (int i = 0; i < 4; i++) begin
      wbuf[i] = wbuf[i + 8];
      sbuf[i] = sbuf[i + 8];
    end
    write_burst(4'h6, 32'h200, 3, axi_mem_pkg::burst_fixed);
    read_burst(4'h7, 32'h200, 3, axi_mem_pkg::burst_fixed);
    end_test("fixed burst", mark);

    mark = errs;
    write_burst(4'h8, 32'((mem_words - 4) * 4), 7, axi_mem_pkg::burst_incr);  // Half out
    read_burst(4'h9, 32'((mem_words - 4) * 4), 7, axi_mem_pkg::burst_incr);
    read_burst(4'hd, 32'h0, 3, axi_mem_pkg::burst_incr);  // Aliases of the out-of-range words
    write_burst(4'ha, 32'h40, 3, axi_mem_pkg::burst_wrap);
    read_burst(4'hb, 32'h40, 3, axi_mem_pkg::burst_wrap);
    read_burst(4'hc, 32'h40, 3, axi_mem_pkg::burst_incr);  // Untouched by the WRAP write
    end_test("decode and burst errors", mark);

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
